// File: compile.f
src/adder_pkg.sv
src/addsub_if.sv
src/brent_kung_adder.sv
src/addsub_datapath.sv
src/addsub_wb_regs.sv
src/addsub_top.sv
tb/addsub_checker.sv
tb/tb_addsub.sv

// File: run.sh
#!/bin/sh
# Build and run the add/sub peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module tb_addsub -f compile.f -o tb_addsub_sim \
  && ./obj_dir/tb_addsub_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb/tb_addsub.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the add/sub peripheral over its Wishbone classic port
// Drives the bus on falling edges, checking is done by addsub_checker
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module tb_addsub import adder_pkg::*; ();

  localparam int half_period  = 4;
  localparam int reset_cycles = 8;
  localparam int n_random     = 200;
  // Reset and register sweeps, add, sub, done handling, early restart
  localparam int n_ops        = 3 + (n_random + 2) + (n_random + 3) + 4 + 4;
  localparam int cycle_limit  = 20 * n_ops + reset_cycles;
  localparam int ack_limit    = 16;
  localparam int poll_limit   = 10;

  logic              clk;
  logic              rst_n;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [adr_w-1:0]  wb_adr;
  logic [data_w-1:0] wb_dat_w;
  logic [data_w-1:0] wb_dat_r;
  logic              wb_ack;

  int          chk_errors;
  int          chk_count;
  int          tb_errors;
  int          tests_passed;
  int          tests_failed;
  int          errors_before;
  int          cycles;
  logic [15:0] lfsr;

  addsub_top addsub_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  addsub_checker addsub_checker_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .err_count   (chk_errors),
    .check_count (chk_count)
  );

  initial clk = 1'b0;
  always #half_period clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Run stopped after %0d cycles before the tests finished", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [data_w-1:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[data_w-2:0], lfsr[0]};
    end
  endtask

  function automatic logic [data_w-1:0] ctrl_word(input logic sub, input logic cin,
                                                  input logic go);
    logic [data_w-1:0] w;
    w = '0;
    w[ctrl_sub_bit] = sub;
    w[ctrl_cin_bit] = cin;
    w[ctrl_go_bit]  = go;
    return w;
  endfunction

  // Single Wishbone classic access, held until ack
  task automatic bus_access(input logic we, input logic [adr_w-3:0] idx,
                            input logic [data_w-1:0] wdata,
                            output logic [data_w-1:0] rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = {idx, 2'b00};
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack && (waited < ack_limit)) begin
      waited++;
      @(negedge clk);
    end
    if (wb_ack) begin
      rdata = wb_dat_r;
    end else begin
      $display("No acknowledge from the DUT for the access to word %0d", idx);
      tb_errors++;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input logic [adr_w-3:0] idx, input logic [data_w-1:0] data);
    logic [data_w-1:0] unused;
    bus_access(1'b1, idx, data, unused);
  endtask

  task automatic read_reg(input logic [adr_w-3:0] idx, output logic [data_w-1:0] data);
    bus_access(1'b0, idx, '0, data);
  endtask

  // Poll status until done shows up
  task automatic wait_done();
    logic [data_w-1:0] st;
    logic              seen;
    seen = 1'b0;
    for (int i = 0; (i < poll_limit) && !seen; i++) begin
      read_reg(reg_status, st);
      seen = st[stat_done_bit];
    end
    if (!seen) begin
      $display("Status done was never set within %0d polls", poll_limit);
      tb_errors++;
    end
  endtask

  task automatic expect_done_clear();
    logic [data_w-1:0] st;
    read_reg(reg_status, st);
    if (st[stat_done_bit]) begin
      $display("ERROR wb_dat_r status done after go: expected %h got %h", 1'b0,
               st[stat_done_bit]);
      tb_errors++;
    end
  endtask

  // Full operation, result read back after done
  task automatic run_op(input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                        input logic sub, input logic cin);
    logic [data_w-1:0] r;
    write_reg(reg_op_a, a);
    write_reg(reg_op_b, b);
    write_reg(reg_ctrl, ctrl_word(sub, cin, 1'b1));
    wait_done();
    read_reg(reg_result, r);
  endtask

  task automatic random_ops(input logic sub);
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] c;
    for (int i = 0; i < n_random; i++) begin
      take_bits(data_w, a);
      take_bits(data_w, b);
      take_bits(1, c);
      run_op(a, b, sub, c[0]);
    end
  endtask

  // Lets the checker finish the last read before counting
  task automatic finish_test(input string name);
    int errs;
    repeat (2) @(negedge clk);
    errs = chk_errors + tb_errors - errors_before;
    if (errs == 0) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errs);
    end
    errors_before = chk_errors + tb_errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [data_w-1:0] r;
    rst_n         = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    tb_errors     = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    errors_before = 0;
    cycles        = 0;
    lfsr          = 16'd12;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;

    // Every word reads zero out of reset
    for (int i = 0; i < 8; i++) begin
      read_reg(i[adr_w-3:0], r);
    end
    finish_test("reset state");

    write_reg(reg_op_a, 32'ha5a5_0f0f);
    write_reg(reg_op_b, 32'h1234_5678);
    write_reg(reg_ctrl, ctrl_word(1'b1, 1'b1, 1'b0));
    write_reg(reg_result, 32'hffff_ffff);
    write_reg(reg_status, 32'hffff_ffff);
    for (int i = 5; i < 8; i++) begin
      write_reg(i[adr_w-3:0], 32'hdead_beef);
    end
    for (int i = 0; i < 8; i++) begin
      read_reg(i[adr_w-3:0], r);
    end
    finish_test("register access");

    // Carry ripples through every bit, then the all-zero sum
    run_op(32'hffff_ffff, 32'h0000_0001, 1'b0, 1'b0);
    run_op(32'h0000_0000, 32'h0000_0000, 1'b0, 1'b0);
    random_ops(1'b0);
    finish_test("addition");

    run_op(32'h1357_9bdf, 32'h1357_9bdf, 1'b1, 1'b1);
    run_op(32'h7fff_ffff, 32'h8000_0000, 1'b1, 1'b1);
    run_op(32'h0000_0000, 32'h0000_0001, 1'b1, 1'b1);
    random_ops(1'b1);
    finish_test("subtraction");

    write_reg(reg_op_a, 32'h0000_1000);
    write_reg(reg_op_b, 32'h0000_0234);
    write_reg(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b1));
    expect_done_clear();
    wait_done();
    write_reg(reg_ctrl, ctrl_word(1'b1, 1'b1, 1'b1));
    expect_done_clear();
    wait_done();
    read_reg(reg_result, r);
    finish_test("done handling");

    // Second go lands as the first one completes
    write_reg(reg_op_a, 32'h0bad_f00d);
    write_reg(reg_op_b, 32'h0000_ffff);
    write_reg(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b1));
    write_reg(reg_ctrl, ctrl_word(1'b1, 1'b1, 1'b1));
    wait_done();
    read_reg(reg_result, r);
    write_reg(reg_ctrl, ctrl_word(1'b0, 1'b1, 1'b1));
    write_reg(reg_op_a, 32'h8000_0001);
    write_reg(reg_op_b, 32'h8000_0002);
    write_reg(reg_ctrl, ctrl_word(1'b0, 1'b0, 1'b1));
    wait_done();
    read_reg(reg_result, r);
    finish_test("early restart");

    $display("Tests passed: %0d, failed: %0d, reads checked: %0d, errors: %0d",
             tests_passed, tests_failed, chk_count, chk_errors + tb_errors);
    if ((tests_failed == 0) && (chk_errors == 0) && (tb_errors == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/addsub_checker.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone monitor for the add/sub peripheral
// Mirrors register writes and compares every acknowledged read
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module addsub_checker import adder_pkg::*; (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              wb_cyc,
  input  wire              wb_stb,
  input  wire              wb_we,
  input  wire [adr_w-1:0]  wb_adr,
  input  wire [data_w-1:0] wb_dat_w,
  input  wire [data_w-1:0] wb_dat_r,
  input  wire              wb_ack,
  output int               err_count,
  output int               check_count
);

  // Register model
  logic [data_w-1:0] m_op_a;
  logic [data_w-1:0] m_op_b;
  logic              m_sub;
  logic              m_cin;
  // Expected {zero, overflow, carry, result} of the latest go
  logic [data_w+2:0] exp_op;
  logic              go_seen;
  logic              result_ok;
  logic              pend_rd;
  logic [adr_w-3:0]  pend_idx;

  // Wide integer arithmetic, carry means no borrow when subtracting
  function automatic logic [data_w+2:0] ref_addsub(input logic [data_w-1:0] a,
                                                   input logic [data_w-1:0] b,
                                                   input logic sub, input logic cin);
    longint            u_sum;
    longint            s_sum;
    longint            lim;
    logic [data_w-1:0] res;
    logic              carry;
    logic              ovf;
    lim = longint'(1) <<< (data_w - 1);
    if (sub) begin
      u_sum = longint'(a) - longint'(b) - longint'(!cin);
      s_sum = longint'(signed'(a)) - longint'(signed'(b)) - longint'(!cin);
      carry = (u_sum >= 0);
    end else begin
      u_sum = longint'(a) + longint'(b) + longint'(cin);
      s_sum = longint'(signed'(a)) + longint'(signed'(b)) + longint'(cin);
      carry = (u_sum >= (longint'(1) <<< data_w));
    end
    res = u_sum[data_w-1:0];
    ovf = (s_sum >= lim) || (s_sum < -lim);
    return {(res == '0), ovf, carry, res};
  endfunction

  function automatic logic [data_w-1:0] status_word(input logic [data_w+2:0] e,
                                                    input logic done);
    logic [data_w-1:0] w;
    w = '0;
    w[stat_carry_bit] = e[data_w];
    w[stat_ovf_bit]   = e[data_w+1];
    w[stat_zero_bit]  = e[data_w+2];
    w[stat_done_bit]  = done;
    return w;
  endfunction

  task automatic compare_word(input string name, input logic [data_w-1:0] expected,
                              input logic [data_w-1:0] actual);
    check_count++;
    if (expected !== actual) begin
      err_count++;
      $display("ERROR wb_dat_r %s: expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic check_read(input logic [adr_w-3:0] idx, input logic [data_w-1:0] data);
    case (idx)
      reg_op_a: compare_word("op_a", m_op_a, data);
      reg_op_b: compare_word("op_b", m_op_b, data);
      reg_ctrl: compare_word("ctrl", {{(data_w-2){1'b0}}, m_cin, m_sub}, data);
      reg_result: begin
        if (!go_seen) begin
          compare_word("result", '0, data);
        end else if (result_ok) begin
          compare_word("result", exp_op[data_w-1:0], data);
        end
      end
      reg_status: begin
        if (!go_seen) begin
          compare_word("status", '0, data);
        end else if (data[stat_done_bit]) begin
          compare_word("status", status_word(exp_op, 1'b1), data);
          result_ok = 1'b1;
        end
      end
      default: compare_word("unmapped word", '0, data);
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus watcher
  ////////////////////////////////////////////////////////////////////////////
  // Request seen before ack, read data taken in the ack cycle
  always @(posedge clk) begin
    if (!rst_n) begin
      m_op_a    = '0;
      m_op_b    = '0;
      m_sub     = 1'b0;
      m_cin     = 1'b0;
      exp_op    = '0;
      go_seen   = 1'b0;
      result_ok = 1'b0;
      pend_rd   = 1'b0;
      pend_idx  = '0;
    end else begin
      if (wb_ack && pend_rd) begin
        check_read(pend_idx, wb_dat_r);
        pend_rd = 1'b0;
      end
      if (wb_cyc && wb_stb && !wb_ack) begin
        if (!wb_we) begin
          pend_rd  = 1'b1;
          pend_idx = wb_adr[adr_w-1:2];
        end else begin
          case (wb_adr[adr_w-1:2])
            reg_op_a: m_op_a = wb_dat_w;
            reg_op_b: m_op_b = wb_dat_w;
            reg_ctrl: begin
              m_sub = wb_dat_w[ctrl_sub_bit];
              m_cin = wb_dat_w[ctrl_cin_bit];
              if (wb_dat_w[ctrl_go_bit]) begin
                go_seen   = 1'b1;
                result_ok = 1'b0;
                exp_op    = ref_addsub(m_op_a, m_op_b, m_sub, m_cin);
              end
            end
            default: ;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/addsub_top.sv
////////////////////////////////////////////////////////////////////////////
// Add/sub peripheral top level with a Wishbone classic slave port
// Joins the register block and the prefix-adder datapath
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module addsub_top import adder_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  // Wishbone classic slave
  input  wire               wb_cyc,
  input  wire               wb_stb,
  input  wire               wb_we,
  input  wire  [adr_w-1:0]  wb_adr,
  input  wire  [data_w-1:0] wb_dat_w,
  output logic [data_w-1:0] wb_dat_r,
  output logic              wb_ack
);

  // Operand request and result handshake
  addsub_if bus_if ();

  // Host side, holds the register map
  addsub_wb_regs addsub_wb_regs_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .bus      (bus_if.regs_mp)
  );

  // Arithmetic side
  addsub_datapath addsub_datapath_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus_if.dp_mp)
  );

endmodule

`default_nettype wire

// File: src/addsub_wb_regs.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone classic register block for the add/sub peripheral
// Holds operands and control, issues start and returns result and status
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module addsub_wb_regs import adder_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               wb_cyc,
  input  wire               wb_stb,
  input  wire               wb_we,
  input  wire  [adr_w-1:0]  wb_adr,
  input  wire  [data_w-1:0] wb_dat_w,
  output logic [data_w-1:0] wb_dat_r,
  output logic              wb_ack,
  addsub_if.regs_mp         bus
);

  logic              active;
  logic              wr_req;
  logic              rd_req;
  logic [adr_w-3:0]  word_idx;
  logic [data_w-1:0] rd_word;

  // Latched copy of the last completed operation
  logic [data_w-1:0] result_q;
  logic              carry_q;
  logic              ovf_q;
  logic              zero_q;
  logic              done_q;

  ////////////////////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////////////////////
  assign active   = wb_cyc && wb_stb;
  // Word index from the byte address
  assign word_idx = wb_adr[adr_w-1:2];

  // The host still holds the finished access while ack is high
  assign wr_req = active && !wb_ack && wb_we;
  assign rd_req = active && !wb_ack && !wb_we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= active && !wb_ack;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Writable registers and start pulse
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus.op_a     <= '0;
      bus.op_b     <= '0;
      bus.sub      <= 1'b0;
      bus.carry_in <= 1'b0;
      bus.start    <= 1'b0;
    end else begin
      bus.start <= 1'b0;
      if (wr_req) begin
        case (word_idx)
          reg_op_a: bus.op_a <= wb_dat_w;
          reg_op_b: bus.op_b <= wb_dat_w;
          reg_ctrl: begin
            bus.sub      <= wb_dat_w[ctrl_sub_bit];
            bus.carry_in <= wb_dat_w[ctrl_cin_bit];
            // Go pulses start in the ack cycle
            bus.start    <= wb_dat_w[ctrl_go_bit];
          end
          // Result, status and holes ignore writes
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result and status capture
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_q <= '0;
      carry_q  <= 1'b0;
      ovf_q    <= 1'b0;
      zero_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      if (bus.done) begin
        result_q <= bus.result;
        carry_q  <= bus.carry_out;
        ovf_q    <= bus.overflow;
        zero_q   <= bus.zero;
        done_q   <= 1'b1;
      end
      // New go marks the pending result stale and wins over a late done
      if (wr_req && (word_idx == reg_ctrl) && wb_dat_w[ctrl_go_bit]) begin
        done_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    rd_word = '0;
    case (word_idx)
      reg_op_a:   rd_word = bus.op_a;
      reg_op_b:   rd_word = bus.op_b;
      reg_ctrl: begin
        rd_word[ctrl_sub_bit] = bus.sub;
        rd_word[ctrl_cin_bit] = bus.carry_in;
      end
      reg_result: rd_word = result_q;
      reg_status: begin
        rd_word[stat_carry_bit] = carry_q;
        rd_word[stat_ovf_bit]   = ovf_q;
        rd_word[stat_zero_bit]  = zero_q;
        rd_word[stat_done_bit]  = done_q;
      end
      // Unmapped words read zero
      default:    rd_word = '0;
    endcase
  end

  // Data valid in the ack cycle only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_dat_r <= '0;
    end else begin
      wb_dat_r <= rd_req ? rd_word : '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  // Every done from the datapath answers a start issued one cycle before
  a_done_follows_start: assert property (
    @(posedge clk) disable iff (!rst_n) bus.done |-> $past(bus.start)
  );

endmodule

`default_nettype wire

// File: src/addsub_datapath.sv
////////////////////////////////////////////////////////////////////////////
// Add/sub datapath around the prefix adder
// Registers result and flags on start and pulses done one cycle later
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module addsub_datapath import adder_pkg::*; (
  input wire    clk,
  input wire    rst_n,
  addsub_if.dp_mp bus
);

  logic [data_w-1:0] b_eff;
  logic [data_w-1:0] sum;
  logic              cout;
  logic              sign_a;
  logic              sign_b;

  // Subtract as a + ~b + cin with carry_in as the no-borrow bit
  assign b_eff = bus.sub ? ~bus.op_b : bus.op_b;

  brent_kung_adder #(
    .width (data_w)
  ) adder_inst (
    .op1  (bus.op_a),
    .op2  (b_eff),
    .cin  (bus.carry_in),
    .sum  (sum),
    .cout (cout)
  );

  // Sign bits seen by the adder after the subtract inversion
  assign sign_a = bus.op_a[data_w-1];
  assign sign_b = b_eff[data_w-1];

  ////////////////////////////////////////////////////////////////////////////
  // Result stage
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus.done <= 1'b0;
    end else begin
      bus.done <= bus.start;
    end
  end

  // Result and flags of the started operation
  always_ff @(posedge clk) begin
    if (bus.start) begin
      bus.result    <= sum;
      bus.carry_out <= cout;
      // Same-sign inputs giving a result of the other sign
      bus.overflow  <= (sign_a == sign_b) && (sum[data_w-1] != sign_a);
      bus.zero      <= (sum == '0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////
  // Register block only issues isolated start pulses
  a_done_single: assert property (
    @(posedge clk) disable iff (!rst_n) bus.done |=> !bus.done
  );

  // Prefix network result against plain addition of the start operands
  a_done_sum: assert property (
    @(posedge clk) disable iff (!rst_n)
    bus.done |-> ({bus.carry_out, bus.result} ==
                  $past({1'b0, bus.op_a} + {1'b0, b_eff} + {{data_w{1'b0}}, bus.carry_in}))
  );

endmodule

`default_nettype wire

// File: src/brent_kung_adder.sv
////////////////////////////////////////////////////////////////////////////
// Combinational Brent-Kung parallel-prefix adder with carry in and out
// Width must be a power of two, default is the package data width
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module brent_kung_adder import adder_pkg::*; #(
  parameter int width = data_w
) (
  input  wire  [width-1:0] op1,
  input  wire  [width-1:0] op2,
  input  wire              cin,
  output logic [width-1:0] sum,
  output logic             cout
);

  // Up-sweep takes lg rows, down-sweep lg-1 rows, plus row zero
  localparam int lg   = $clog2(width);
  localparam int rows = 2 * lg;

  wire [width-1:0] g_row [rows];
  wire [width-1:0] p_row [rows];
  wire [width-1:0] p_raw;
  wire [width-1:0] carry;

  ////////////////////////////////////////////////////////////////////////////
  // Row zero
  ////////////////////////////////////////////////////////////////////////////
  assign p_raw = op1 ^ op2;

  assign g_row[0][width-1:1] = op1[width-1:1] & op2[width-1:1];
  assign p_row[0][width-1:1] = p_raw[width-1:1];

  // Bit 0 absorbs cin, so its group never propagates further
  assign g_row[0][0] = (op1[0] & op2[0]) | (op1[0] & cin) | (op2[0] & cin);
  assign p_row[0][0] = 1'b0;

  ////////////////////////////////////////////////////////////////////////////
  // Up-sweep rows 1 to lg
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = 1; i <= lg; i++) begin : g_up
    for (genvar j = 0; j < width; j++) begin : g_bit
      // Cell on every 2**i-th bit, spanning 2**(i-1) bits back
      if (((j + 1) % (2 ** i)) == 0) begin : g_cell
        localparam int k = j - 2 ** (i - 1);
        assign g_row[i][j] = g_row[i-1][j] | (p_row[i-1][j] & g_row[i-1][k]);
        assign p_row[i][j] = p_row[i-1][j] & p_row[i-1][k];
      end else begin : g_pass
        assign g_row[i][j] = g_row[i-1][j];
        assign p_row[i][j] = p_row[i-1][j];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Down-sweep rows lg+1 to 2*lg-1
  ////////////////////////////////////////////////////////////////////////////
  for (genvar i = lg + 1; i < rows; i++) begin : g_down
    // Distance between cells in this row
    localparam int step  = width / (2 ** (i - lg));
    // Lowest bit that gets a cell in this row
    localparam int first = (width / (2 ** (i - lg + 1))) * 3 - 1;
    for (genvar j = 0; j < width; j++) begin : g_bit
      if ((j >= first) && (((j - first) % step) == 0)) begin : g_cell
        localparam int k = j - step / 2;
        assign g_row[i][j] = g_row[i-1][j] | (p_row[i-1][j] & g_row[i-1][k]);
        assign p_row[i][j] = p_row[i-1][j] & p_row[i-1][k];
      end else begin : g_pass
        assign g_row[i][j] = g_row[i-1][j];
        assign p_row[i][j] = p_row[i-1][j];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sum
  ////////////////////////////////////////////////////////////////////////////
  // Last row holds the carry out of every bit position
  assign carry = {g_row[rows-1][width-2:0], cin};
  assign sum   = p_raw ^ carry;
  assign cout  = g_row[rows-1][width-1];

endmodule

`default_nettype wire

// File: src/addsub_if.sv
////////////////////////////////////////////////////////////////////////////
// Link between the Wishbone register block and the add/sub datapath
// start and done are single-cycle pulses
////////////////////////////////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/1ps

interface addsub_if import adder_pkg::*; ();

  // Request side, owned by the register block
  logic [data_w-1:0] op_a;
  logic [data_w-1:0] op_b;
  logic              sub;
  logic              carry_in;
  logic              start;

  // Response side, owned by the datapath
  logic [data_w-1:0] result;
  logic              carry_out;
  logic              overflow;
  logic              zero;
  logic              done;

  modport regs_mp (
    output op_a, op_b, sub, carry_in, start,
    input  result, carry_out, overflow, zero, done
  );

  modport dp_mp (
    input  op_a, op_b, sub, carry_in, start,
    output result, carry_out, overflow, zero, done
  );

endinterface

`default_nettype wire

// File: src/adder_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, register map and bit positions for the add/sub peripheral
// Imported by wildcard in the header of every module that needs them
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package adder_pkg;

  // Operand and result width
  localparam int data_w = 32;

  // Byte address width of the Wishbone port, word index is adr_w-2 bits
  localparam int adr_w = 5;

  //////////////////////////////////////////////////////////////////////////
  // Register map, word indices
  //////////////////////////////////////////////////////////////////////////
  localparam logic [adr_w-3:0] reg_op_a   = 'd0;
  localparam logic [adr_w-3:0] reg_op_b   = 'd1;
  localparam logic [adr_w-3:0] reg_ctrl   = 'd2;
  localparam logic [adr_w-3:0] reg_result = 'd3;
  localparam logic [adr_w-3:0] reg_status = 'd4;

  // Control word bits
  // Go is a write-only strobe and reads back as zero
  localparam int ctrl_sub_bit = 0;
  localparam int ctrl_cin_bit = 1;
  localparam int ctrl_go_bit  = 2;

  // Status word bits
  localparam int stat_carry_bit = 0;
  localparam int stat_ovf_bit   = 1;
  localparam int stat_zero_bit  = 2;
  localparam int stat_done_bit  = 3;

endpackage

`default_nettype wire
